/* mpa_core_top.f */
logic/mpa_pkg.sv
logic/mpa_fetch_ctrl.sv
logic/mpa_reg_file.sv
logic/mpa_dm_lane.sv
logic/mpa_data_return.sv
logic/mpa_core_top.sv
bench/tb_mpa_core_assert.sv
bench/tb_mpa_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mpa_core
FILELIST  ?= mpa_core_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

FAIL_MSG  := Some tests failed
PASS_MSG  := All tests passed
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL (exit $$status)"; exit 1; \
	else echo "PASS"; fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/tb_mpa_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mpa_core;

    localparam int          IM_DEPTH    = 32;
    localparam int          DM_DEPTH    = 32;
    localparam logic [31:0] RESET_PC    = 32'd0;
    localparam int          RUN_LIMIT   = IM_DEPTH;  // Program never longer than IM
    localparam int          WATCHDOG_NS = 100000;

    localparam logic [1:0] PH_WR  = 2'd0;  // Back door write
    localparam logic [1:0] PH_RUN = 2'd1;  // addr field holds instruction count
    localparam logic [1:0] PH_RD  = 2'd2;  // Back door read and compare

    typedef struct packed {
        logic [1:0]  phase;
        logic [1:0]  func;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp_val;
    } step_t;

    logic        mem_debug_clk_gate;
    logic        HW_RSTn;
    logic        mem_debug;
    logic        debug_we;
    logic        debug_re;
    logic [1:0]  debug_func;
    logic [31:0] addr;
    logic [31:0] din;
    wire  [31:0] dout;

    step_t       steps[$];          // Stimulus table
    logic [31:0] prog[$];           // Load program
    logic [31:0] im_m [32];         // Reference model of IM, DM and registers
    logic [31:0] dm_m [32];
    logic [31:0] rf_m [32];
    logic [31:0] lfsr_q  = 32'h6145c59d;
    int          err_cnt = 0;

    mpa_core_top #(
        .IM_DEPTH (IM_DEPTH),
        .DM_DEPTH (DM_DEPTH),
        .RESET_PC (RESET_PC)
    ) i_dut (
        .mem_debug_clk_gate (mem_debug_clk_gate),
        .HW_RSTn            (HW_RSTn),
        .mem_debug          (mem_debug),
        .debug_we           (debug_we),
        .debug_re           (debug_re),
        .debug_func         (debug_func),
        .addr               (addr),
        .din                (din),
        .dout               (dout)
    );

    initial begin
        mem_debug_clk_gate = 1'b0;
        forever #2 mem_debug_clk_gate = ~mem_debug_clk_gate;  // 4 ns period
    end

    // Guard against a stuck run
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: stimulus table did not complete within %0d ns", WATCHDOG_NS);
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

    // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);  // One step per bit
            v      = {v[30:0], lfsr_q[0]};
        end
    endtask

    function automatic logic [31:0] enc(input logic [5:0] op, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};  // I format
    endfunction

    function automatic logic [31:0] model_read(input logic [1:0] f, input logic [31:0] a);
        case (f)
            mpa_pkg::DBG_IM: return im_m[a[6:2]];
            mpa_pkg::DBG_DM: return dm_m[a[6:2]];
            mpa_pkg::DBG_MR: return rf_m[a[4:0]];
            default:         return '0;
        endcase
    endfunction

    task automatic add_write(input logic [1:0] f, input logic [31:0] a, input logic [31:0] d);
        steps.push_back({PH_WR, f, a, d, 32'd0});
        case (f)
            mpa_pkg::DBG_IM: im_m[a[6:2]] = d;
            mpa_pkg::DBG_DM: dm_m[a[6:2]] = d;
            mpa_pkg::DBG_MR: if (a[4:0] != 5'd0) rf_m[a[4:0]] = d;  // $zero stays 0
            default: ;
        endcase
    endtask

    task automatic add_read(input logic [1:0] f, input logic [31:0] a);
        steps.push_back({PH_RD, f, a, 32'd1, model_read(f, a)});  // Read enable high
    endtask

    task automatic exec_model(input logic [31:0] iw);
        logic [31:0] ea;
        logic [31:0] w;
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] v;
        logic        hit;
        ea  = rf_m[iw[25:21]] + {{16{iw[15]}}, iw[15:0]};
        w   = dm_m[ea[6:2]];
        b   = 8'(w >> {ea[1:0], 3'b000});  // Byte at offset
        h   = 16'(w >> {ea[1], 4'b0000});  // Halfword at offset
        v   = w;
        hit = 1'b1;
        case (iw[31:26])
            mpa_pkg::OP_LB:  v = {{24{b[7]}}, b};
            mpa_pkg::OP_LBU: v = {24'd0, b};
            mpa_pkg::OP_LH:  v = {{16{h[15]}}, h};
            mpa_pkg::OP_LHU: v = {16'd0, h};
            mpa_pkg::OP_LW:  v = w;
            mpa_pkg::OP_LUI: v = {iw[15:0], 16'd0};
            default:         hit = 1'b0;  // Anything else is a no-op
        endcase
        if (hit && (iw[20:16] != 5'd0)) rf_m[iw[20:16]] = v;
    endtask

    task automatic add_run(input int n);
        steps.push_back({PH_RUN, 2'd0, 32'(n), 32'd0, 32'd0});
        for (int p = 0; p < n; p++) exec_model(im_m[p]);  // PC starts at 0
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp_val, input string what);
        if (got !== exp_val) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp_val);
            $display("Some tests failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    // Drops mem_debug for n edges, one instruction retires per edge
    task automatic run_core(input int n);
        int cyc;
        cyc        = 0;
        mem_debug  <= 1'b0;
        debug_we   <= 1'b0;
        debug_func <= 2'd0;
        while (cyc < n) begin
            @(posedge mem_debug_clk_gate);
            cyc++;
            if (cyc > RUN_LIMIT) begin
                $display("Timeout: run phase exceeded %0d cycles", RUN_LIMIT);
                $display("Some tests failed");
                $fatal(1, "run phase did not end");
            end
        end
        mem_debug <= 1'b1;  // Halt again after the last instruction
    endtask

    initial begin
        logic [31:0] d;
        step_t       s;
        HW_RSTn    = 1'b0;
        mem_debug  = 1'b1;  // Start halted
        debug_we   = 1'b0;
        debug_re   = 1'b0;
        debug_func = 2'd0;
        addr       = '0;
        din        = '0;
        for (int k = 0; k < 32; k++) begin
            im_m[k] = '0;
            dm_m[k] = '0;
            rf_m[k] = '0;
        end

        // DM words, word 16 gets mixed byte signs
        for (int w = 0; w < 32; w++) begin
            take_bits(32, d);
            if (w == 16) d = (d | 32'h8000_8080) & 32'hff7f_ffff;
            add_write(mpa_pkg::DBG_DM, 32'(w * 4), d);
        end
        for (int r = 0; r < 32; r++) begin
            take_bits(32, d);
            if (r == 1) d = 32'h40;  // Base address, word 16
            add_write(mpa_pkg::DBG_MR, 32'(r), d);
        end

        prog.push_back(enc(mpa_pkg::OP_LW, 5'd1, 5'd2, 16'hfffc));  // Negative offset
        prog.push_back(enc(mpa_pkg::OP_LW, 5'd1, 5'd3, 16'd8));
        for (int k = 0; k < 4; k++) prog.push_back(enc(mpa_pkg::OP_LB, 5'd1, 5'(4 + k), 16'(k)));
        for (int k = 0; k < 4; k++) prog.push_back(enc(mpa_pkg::OP_LBU, 5'd1, 5'(8 + k), 16'(k)));
        prog.push_back(enc(mpa_pkg::OP_LH, 5'd1, 5'd12, 16'd0));
        prog.push_back(enc(mpa_pkg::OP_LH, 5'd1, 5'd13, 16'd2));
        prog.push_back(enc(mpa_pkg::OP_LHU, 5'd1, 5'd14, 16'd0));
        prog.push_back(enc(mpa_pkg::OP_LHU, 5'd1, 5'd15, 16'd2));
        take_bits(16, d);
        prog.push_back(enc(mpa_pkg::OP_LUI, 5'd0, 5'd16, d[15:0]));
        prog.push_back(enc(6'b10_1011, 5'd1, 5'd17, 16'd0));         // SW, dropped
        prog.push_back(enc(mpa_pkg::OP_LW, 5'd1, 5'd0, 16'd4));      // Load into $zero
        for (int p = 0; p < prog.size(); p++) add_write(mpa_pkg::DBG_IM, 32'(p * 4), prog[p]);

        for (int k = 0; k < 32; k++) add_read(mpa_pkg::DBG_IM, 32'(k * 4));
        for (int k = 0; k < 32; k++) add_read(mpa_pkg::DBG_DM, 32'(k * 4));
        for (int k = 0; k < 32; k++) add_read(mpa_pkg::DBG_MR, 32'(k));
        add_read(2'd0, 32'h10);  // No target
        steps.push_back({PH_RD, mpa_pkg::DBG_DM, 32'h40, 32'd0, 32'd0});  // debug_re low
        add_run(prog.size());
        for (int k = 0; k < 32; k++) add_read(mpa_pkg::DBG_MR, 32'(k));
        for (int k = 0; k < 32; k++) add_read(mpa_pkg::DBG_DM, 32'(k * 4));

        for (int c = 0; c < 5; c++) @(posedge mem_debug_clk_gate);
        HW_RSTn <= 1'b1;

        for (int i = 0; i < steps.size(); i++) begin
            s = steps[i];
            @(posedge mem_debug_clk_gate);
            case (s.phase)
                PH_WR: begin
                    debug_func <= s.func;
                    addr       <= s.addr;
                    din        <= s.data;
                    debug_we   <= 1'b1;  // Lands at next edge
                    debug_re   <= 1'b0;
                end
                PH_RUN: run_core(int'(s.addr));
                default: begin
                    debug_func <= s.func;
                    addr       <= s.addr;
                    debug_we   <= 1'b0;
                    debug_re   <= s.data[0];  // Read enable from the data field
                    @(negedge mem_debug_clk_gate);  // dout settled
                    check(dout, s.exp_val,
                          $sformatf("step %0d func %0d addr %h", i, s.func, s.addr));
                end
            endcase
        end
        @(posedge mem_debug_clk_gate);
        debug_we <= 1'b0;

        err_cnt += i_dut.i_fetch_ctrl.i_assert.fail_cnt;
        if (err_cnt == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Some tests failed");
            $fatal(1, "assertion failures in fetch control");
        end
    end

endmodule

`default_nettype wire

/* bench/tb_mpa_core_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mpa_core_assert #(
    parameter logic [31:0] RESET_PC = 32'd0
) (
    input wire        mem_debug_clk_gate,
    input wire        HW_RSTn,
    input wire        mem_debug,
    input wire [1:0]  debug_func,
    input wire [31:0] pc,
    input wire        wr_en
);

    int fail_cnt = 0;  // Read by the testbench at the end

    // Running core steps PC by one word
    a_pc_step: assert property (@(posedge mem_debug_clk_gate) disable iff (!HW_RSTn)
        !mem_debug |=> pc == $past(pc) + 32'd4)
        else begin
            fail_cnt++;
            $error("PC did not advance by 4 while running");
        end

    a_pc_hold: assert property (@(posedge mem_debug_clk_gate) disable iff (!HW_RSTn)
        mem_debug |=> pc == RESET_PC)
        else begin
            fail_cnt++;
            $error("PC left the reset address while halted");
        end

    // Back door register write only when MR is selected
    a_dbg_wr: assert property (@(posedge mem_debug_clk_gate) disable iff (!HW_RSTn)
        (mem_debug && wr_en) |-> (debug_func == mpa_pkg::DBG_MR))
        else begin
            fail_cnt++;
            $error("Register write enable high in debug without MR target");
        end

endmodule

bind mpa_fetch_ctrl tb_mpa_core_assert #(
    .RESET_PC (RESET_PC)
) i_assert (
    .mem_debug_clk_gate (mem_debug_clk_gate),
    .HW_RSTn            (HW_RSTn),
    .mem_debug          (mem_debug),
    .debug_func         (debug_func),
    .pc                 (pc),
    .wr_en              (wr_en)
);

`default_nettype wire

/* logic/mpa_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mpa_core_top #(
    parameter int          IM_DEPTH = 32,
    parameter int          DM_DEPTH = 32,
    parameter logic [31:0] RESET_PC = 32'd0
) (
    input  wire                        mem_debug_clk_gate,
    input  wire                        HW_RSTn,
    input  wire                        mem_debug,    // Halt and open back door
    input  wire                        debug_we,
    input  wire                        debug_re,
    input  wire [1:0]                  debug_func,   // IM, DM, MR as 1, 2, 3
    input  wire [mpa_pkg::WORD_W-1:0]  addr,
    input  wire [mpa_pkg::WORD_W-1:0]  din,
    output wire [mpa_pkg::WORD_W-1:0]  dout
);

    // Fetch/control outputs
    wire [mpa_pkg::WORD_W-1:0]     instr;
    wire [mpa_pkg::REG_ADDR_W-1:0] rs_idx;
    wire [mpa_pkg::REG_ADDR_W-1:0] rd1_idx;
    wire [mpa_pkg::REG_ADDR_W-1:0] wr_addr;
    wire                           wr_en;
    wire [mpa_pkg::WB_W-1:0]       wb_sel;
    wire [4:0]                     dm_index;
    wire [1:0]                     byte_off;
    wire [mpa_pkg::LANES-1:0]      lane_we;
    wire [mpa_pkg::WORD_W-1:0]     dm_wdata;
    wire [15:0]                    imm;

    // Register file and memory returns
    wire [mpa_pkg::WORD_W-1:0]     rd0_data;
    wire [mpa_pkg::WORD_W-1:0]     rd1_data;
    wire [mpa_pkg::WORD_W-1:0]     wr_data;
    wire [mpa_pkg::WORD_W-1:0]     dm_word;  // All lanes packed, lane 0 lowest

    mpa_fetch_ctrl #(
        .IM_DEPTH (IM_DEPTH),
        .RESET_PC (RESET_PC)
    ) i_fetch_ctrl (
        .mem_debug_clk_gate (mem_debug_clk_gate),
        .HW_RSTn            (HW_RSTn),
        .mem_debug          (mem_debug),
        .debug_we           (debug_we),
        .debug_func         (debug_func),
        .addr               (addr),
        .din                (din),
        .rs_data            (rd0_data),
        .instr              (instr),
        .rs_idx             (rs_idx),
        .rd1_idx            (rd1_idx),
        .wr_addr            (wr_addr),
        .wr_en              (wr_en),
        .wb_sel             (wb_sel),
        .dm_index           (dm_index),
        .byte_off           (byte_off),
        .lane_we            (lane_we),
        .dm_wdata           (dm_wdata),
        .imm                (imm)
    );

    mpa_reg_file i_reg_file (
        .mem_debug_clk_gate (mem_debug_clk_gate),
        .HW_RSTn            (HW_RSTn),
        .rs_idx             (rs_idx),
        .rd1_idx            (rd1_idx),
        .wr_addr            (wr_addr),
        .wr_en              (wr_en),
        .wr_data            (wr_data),
        .rd0_data           (rd0_data),
        .rd1_data           (rd1_data)
    );

    // One byte bank per lane
    for (genvar g = 0; g < mpa_pkg::LANES; g++) begin : g_lane
        mpa_dm_lane #(
            .DM_DEPTH (DM_DEPTH)
        ) i_dm_lane (
            .mem_debug_clk_gate (mem_debug_clk_gate),
            .HW_RSTn            (HW_RSTn),
            .dm_index           (dm_index),
            .we                 (lane_we[g]),
            .wdata              (dm_wdata[g*8 +: 8]),
            .rdata              (dm_word[g*8 +: 8])
        );
    end

    mpa_data_return i_data_return (
        .dm_word    (dm_word),
        .byte_off   (byte_off),
        .imm        (imm),
        .din        (din),
        .wb_sel     (wb_sel),
        .instr      (instr),
        .rd1_data   (rd1_data),
        .debug_func (debug_func),
        .debug_re   (debug_re),
        .wr_data    (wr_data),
        .dout       (dout)
    );

endmodule

`default_nettype wire

/* logic/mpa_data_return.sv */
`timescale 1ns/1ps
`default_nettype none

module mpa_data_return (
    input  wire [mpa_pkg::WORD_W-1:0]  dm_word,
    input  wire [1:0]                  byte_off,
    input  wire [15:0]                 imm,
    input  wire [mpa_pkg::WORD_W-1:0]  din,
    input  wire [mpa_pkg::WB_W-1:0]    wb_sel,
    input  wire [mpa_pkg::WORD_W-1:0]  instr,
    input  wire [mpa_pkg::WORD_W-1:0]  rd1_data,
    input  wire [1:0]                  debug_func,
    input  wire                        debug_re,   // Gates DM reads only
    output logic [mpa_pkg::WORD_W-1:0] wr_data,
    output logic [mpa_pkg::WORD_W-1:0] dout
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // Lane picked by low address bits
    assign byte_sel = dm_word[byte_off*8 +: 8];
    assign half_sel = byte_off[1] ? dm_word[31:16] : dm_word[15:0];  // Bit 0 ignored

    always_comb begin
        case (wb_sel)
            mpa_pkg::WB_BYTE_S: wr_data = {{24{byte_sel[7]}}, byte_sel};
            mpa_pkg::WB_BYTE_U: wr_data = {24'd0, byte_sel};
            mpa_pkg::WB_HALF_S: wr_data = {{16{half_sel[15]}}, half_sel};
            mpa_pkg::WB_HALF_U: wr_data = {16'd0, half_sel};
            mpa_pkg::WB_UPPER:  wr_data = {imm, 16'd0};
            mpa_pkg::WB_DEBUG:  wr_data = din;       // Back door write
            default:            wr_data = dm_word;   // LW
        endcase
    end

    // Back door read mux
    always_comb begin
        case (debug_func)
            mpa_pkg::DBG_IM: dout = instr;
            mpa_pkg::DBG_DM: dout = debug_re ? dm_word : '0;
            mpa_pkg::DBG_MR: dout = rd1_data;
            default:         dout = '0;  // No target
        endcase
    end

endmodule

`default_nettype wire

/* logic/mpa_dm_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module mpa_dm_lane #(
    parameter int DM_DEPTH = 32
) (
    input  wire        mem_debug_clk_gate,
    input  wire        HW_RSTn,
    input  wire [4:0]  dm_index,  // Word index, shared by all lanes
    input  wire        we,
    input  wire [7:0]  wdata,
    output logic [7:0] rdata
);

    localparam int DM_AW = $clog2(DM_DEPTH);

    logic [7:0] mem [DM_DEPTH];

    always_ff @(posedge mem_debug_clk_gate or negedge HW_RSTn) begin
        if (!HW_RSTn) begin
            for (int w = 0; w < DM_DEPTH; w++) begin
                mem[w] <= '0;
            end
        end else if (we) begin
            mem[dm_index[DM_AW-1:0]] <= wdata;
        end
    end

    assign rdata = mem[dm_index[DM_AW-1:0]];  // Async read

endmodule

`default_nettype wire

/* logic/mpa_reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module mpa_reg_file (
    input  wire                            mem_debug_clk_gate,
    input  wire                            HW_RSTn,
    input  wire [mpa_pkg::REG_ADDR_W-1:0]  rs_idx,
    input  wire [mpa_pkg::REG_ADDR_W-1:0]  rd1_idx,   // rt, or debug index
    input  wire [mpa_pkg::REG_ADDR_W-1:0]  wr_addr,
    input  wire                            wr_en,
    input  wire [mpa_pkg::WORD_W-1:0]      wr_data,
    output logic [mpa_pkg::WORD_W-1:0]     rd0_data,
    output logic [mpa_pkg::WORD_W-1:0]     rd1_data
);

    localparam int NREGS = 1 << mpa_pkg::REG_ADDR_W;

    logic [mpa_pkg::WORD_W-1:0] regs [NREGS];

    // $zero is never written so it stays at its reset value
    always_ff @(posedge mem_debug_clk_gate or negedge HW_RSTn) begin
        if (!HW_RSTn) begin
            for (int r = 0; r < NREGS; r++) begin
                regs[r] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Two combinational read ports
    assign rd0_data = regs[rs_idx];
    assign rd1_data = regs[rd1_idx];

endmodule

`default_nettype wire

/* logic/mpa_fetch_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module mpa_fetch_ctrl #(
    parameter int          IM_DEPTH = 32,
    parameter logic [31:0] RESET_PC = 32'd0
) (
    input  wire                            mem_debug_clk_gate,
    input  wire                            HW_RSTn,
    input  wire                            mem_debug,
    input  wire                            debug_we,
    input  wire [1:0]                      debug_func,
    input  wire [mpa_pkg::WORD_W-1:0]      addr,
    input  wire [mpa_pkg::WORD_W-1:0]      din,
    input  wire [mpa_pkg::WORD_W-1:0]      rs_data,   // Base register for loads
    output logic [mpa_pkg::WORD_W-1:0]     instr,
    output logic [mpa_pkg::REG_ADDR_W-1:0] rs_idx,
    output logic [mpa_pkg::REG_ADDR_W-1:0] rd1_idx,
    output logic [mpa_pkg::REG_ADDR_W-1:0] wr_addr,
    output logic                           wr_en,
    output logic [mpa_pkg::WB_W-1:0]       wb_sel,
    output logic [4:0]                     dm_index,
    output logic [1:0]                     byte_off,
    output logic [mpa_pkg::LANES-1:0]      lane_we,
    output logic [mpa_pkg::WORD_W-1:0]     dm_wdata,
    output logic [15:0]                    imm
);

    localparam int IM_AW = $clog2(IM_DEPTH);

    logic [mpa_pkg::WORD_W-1:0] pc;
    logic [mpa_pkg::WORD_W-1:0] im [IM_DEPTH];
    logic [IM_AW-1:0]           im_idx;
    logic                       im_we;
    mpa_pkg::instr_word_u       iw;
    logic                       is_load;   // Any of the six kept opcodes
    logic [mpa_pkg::WB_W-1:0]   core_wb;
    logic [mpa_pkg::WORD_W-1:0] ea;        // Effective address

    // PC held at reset address while halted
    always_ff @(posedge mem_debug_clk_gate or negedge HW_RSTn) begin
        if (!HW_RSTn) begin
            pc <= RESET_PC;
        end else if (mem_debug) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc + 32'd4;  // No branches kept
        end
    end

    // Back door addresses IM by word, core by PC
    assign im_idx = mem_debug ? addr[IM_AW+1:2] : pc[IM_AW+1:2];
    assign im_we  = mem_debug && debug_we && (debug_func == mpa_pkg::DBG_IM);

    always_ff @(posedge mem_debug_clk_gate or negedge HW_RSTn) begin
        if (!HW_RSTn) begin
            for (int w = 0; w < IM_DEPTH; w++) begin
                im[w] <= '0;
            end
        end else if (im_we) begin
            im[im_idx] <= din;
        end
    end

    assign iw    = im[im_idx];
    assign instr = iw;
    assign imm   = iw.i.imm;

    // Opcode decode, funct of R type never matters here
    always_comb begin
        is_load = 1'b1;
        core_wb = mpa_pkg::WB_WORD;
        case (iw.r.opcode)
            mpa_pkg::OP_LB:  core_wb = mpa_pkg::WB_BYTE_S;
            mpa_pkg::OP_LBU: core_wb = mpa_pkg::WB_BYTE_U;
            mpa_pkg::OP_LH:  core_wb = mpa_pkg::WB_HALF_S;
            mpa_pkg::OP_LHU: core_wb = mpa_pkg::WB_HALF_U;
            mpa_pkg::OP_LW:  core_wb = mpa_pkg::WB_WORD;
            mpa_pkg::OP_LUI: core_wb = mpa_pkg::WB_UPPER;
            default:         is_load = 1'b0;  // Treated as no-op
        endcase
    end

    // rs plus sign-extended offset
    assign ea = rs_data + {{16{iw.i.imm[15]}}, iw.i.imm};

    // Debug versus core selection of every index and enable
    assign rs_idx  = iw.i.rs;
    assign rd1_idx = mem_debug ? addr[4:0] : iw.i.rt;     // Debug reads MR here
    assign wr_addr = mem_debug ? addr[4:0] : iw.i.rt;
    assign wr_en   = mem_debug ? (debug_we && (debug_func == mpa_pkg::DBG_MR)) : is_load;
    assign wb_sel  = mem_debug ? mpa_pkg::WB_DEBUG : core_wb;

    assign dm_index = mem_debug ? addr[6:2] : ea[6:2];
    assign byte_off = mem_debug ? addr[1:0] : ea[1:0];
    // Only the back door writes data memory, always a full word
    assign lane_we  = (mem_debug && debug_we && (debug_func == mpa_pkg::DBG_DM)) ?
                      {mpa_pkg::LANES{1'b1}} : '0;
    assign dm_wdata = mem_debug ? din : '0;

endmodule

`default_nettype wire

/* logic/mpa_pkg.sv */
`default_nettype none

package mpa_pkg;

    // Datapath widths
    parameter int WORD_W     = 32;
    parameter int REG_ADDR_W = 5;
    parameter int LANES      = 4;  // Byte banks in data memory

    // Load opcodes, everything else runs as a no-op
    parameter logic [5:0] OP_LB  = 6'b10_0000;
    parameter logic [5:0] OP_LH  = 6'b10_0001;
    parameter logic [5:0] OP_LW  = 6'b10_0011;
    parameter logic [5:0] OP_LBU = 6'b10_0100;
    parameter logic [5:0] OP_LHU = 6'b10_0101;
    parameter logic [5:0] OP_LUI = 6'b00_1111;

    // Register write data source
    parameter int WB_W = 3;
    parameter logic [WB_W-1:0] WB_BYTE_S = 3'd0;
    parameter logic [WB_W-1:0] WB_BYTE_U = 3'd1;
    parameter logic [WB_W-1:0] WB_HALF_S = 3'd2;
    parameter logic [WB_W-1:0] WB_HALF_U = 3'd3;
    parameter logic [WB_W-1:0] WB_WORD   = 3'd4;
    parameter logic [WB_W-1:0] WB_UPPER  = 3'd5;  // LUI
    parameter logic [WB_W-1:0] WB_DEBUG  = 3'd6;  // Back door write from din

    // Back door targets, 0 selects nothing
    parameter logic [1:0] DBG_IM = 2'd1;
    parameter logic [1:0] DBG_DM = 2'd2;
    parameter logic [1:0] DBG_MR = 2'd3;

    // Instruction word, opcode sits in the same bits in both views
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;    // Load destination
            logic [15:0] imm;
        } i;
    } instr_word_u;

endpackage

`default_nettype wire
